//--- design/bus_pkg.sv
package bus_pkg;

  parameter int ADDR_W    = 32;
  parameter int WORD_W    = 32;
  parameter int OPERAND_W = 28;  // low instruction bits, zero-extended to an address

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [7:0]        byte_t;
  typedef logic [3:0]        slot_t;  // 0 idle, 1..9 frame slots

  // opcode sits in the top nibble of the instruction word
  typedef enum logic [3:0] {
    LDA = 4'd1,
    ADD = 4'd2,
    STA = 4'd3,
    JMP = 4'd4,
    JZ  = 4'd5,
    HLT = 4'd6
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    MEM,
    HALTED
  } cpu_state_t;

  localparam slot_t SLOT_IDLE = 4'd0;
  localparam slot_t SLOT_CMD  = 4'd5;  // command byte, last driven slot
  localparam slot_t SLOT_RD0  = 4'd6;  // first read byte
  localparam slot_t SLOT_LAST = 4'd9;

endpackage

//--- design/cpu_bus_if.sv
`timescale 1ns/1ns

// one processor access, valid/ready handshake
interface cpu_bus_if (
  input logic clk
);
  import bus_pkg::*;

  logic  valid;   // held until ready seen
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  ready;   // single cycle pulse
  word_t rdata;   // good while ready is high

  modport cpu (
    input  clk,
    output valid,
    output we,
    output addr,
    output wdata,
    input  ready,
    input  rdata
  );

  modport bridge (
    input  clk,
    input  valid,
    input  we,
    input  addr,
    input  wdata,
    output ready,
    output rdata
  );

endinterface

//--- design/acc_cpu.sv
`timescale 1ns/1ns

module acc_cpu #(
  parameter bus_pkg::addr_t RESET_VECTOR = '0
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   run,
  cpu_bus_if.cpu bus
);
  import bus_pkg::*;

  cpu_state_t state;
  addr_t      pc;
  word_t      acc;
  word_t      ir;       // instruction of the current step

  opcode_t    op;
  addr_t      operand;
  logic       done;     // handshake completes at this edge
  logic       fetch_go; // raise an instruction fetch
  logic       mem_go;   // raise the data access
  logic       acc_zero;
  addr_t      pc_inc;

  assign op       = opcode_t'(ir[WORD_W-1:OPERAND_W]);
  assign operand  = addr_t'(ir[OPERAND_W-1:0]);
  assign done     = bus.valid && bus.ready;
  assign acc_zero = (acc == '0);
  assign pc_inc   = pc + 32'd4;

  // a new access only goes out while run is high
  assign fetch_go = (state == FETCH) && run && !bus.valid;
  assign mem_go   = (state == MEM) && run && !bus.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FETCH;
      pc        <= RESET_VECTOR;
      acc       <= '0;
      bus.valid <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (fetch_go) begin
            bus.valid <= 1'b1;
          end else if (done) begin
            bus.valid <= 1'b0;
            state     <= EXEC;
          end
        end

        EXEC: begin
          case (op)
            LDA, ADD, STA: begin
              state <= MEM;
            end
            JMP: begin
              pc    <= operand;
              state <= FETCH;
            end
            JZ: begin
              pc    <= acc_zero ? operand : pc_inc; // untaken falls through
              state <= FETCH;
            end
            HLT: begin
              state <= HALTED;
            end
            default: begin  // unused opcodes do nothing
              pc    <= pc_inc;
              state <= FETCH;
            end
          endcase
        end

        MEM: begin
          if (mem_go) begin
            bus.valid <= 1'b1;
          end else if (done) begin
            bus.valid <= 1'b0;
            pc        <= pc_inc;
            state     <= FETCH;
            if (op == LDA) begin
              acc <= bus.rdata;
            end else if (op == ADD) begin
              acc <= acc + bus.rdata;  // wraps at 32 bits
            end
          end
        end

        HALTED: begin
          state <= HALTED;  // stays here until reset
        end

        default: begin
          state <= FETCH;
        end
      endcase
    end
  end

  // access payload, loaded together with valid
  always_ff @(posedge clk) begin
    if (fetch_go) begin
      bus.addr  <= pc;
      bus.we    <= 1'b0;
      bus.wdata <= acc;
    end else if (mem_go) begin
      bus.addr  <= operand;
      bus.we    <= (op == STA);
      bus.wdata <= acc;
    end

    if ((state == FETCH) && done) begin
      ir <= bus.rdata;
    end
  end

endmodule

//--- design/pin_bridge.sv
`timescale 1ns/1ns

module pin_bridge (
  input  logic           clk,
  input  logic           rst_n,
  cpu_bus_if.bridge      bus,
  output bus_pkg::byte_t uo_out,
  output bus_pkg::byte_t uio_out,
  output bus_pkg::byte_t uio_oe,
  input  bus_pkg::byte_t uio_in
);
  import bus_pkg::*;

  slot_t      slot;       // slot now on the pins
  slot_t      slot_nxt;
  logic       start;

  addr_t      addr_q;
  word_t      wdata_q;
  logic       we_q;
  word_t      rd_shift;   // read bytes, lsb first

  addr_t      frame_addr;
  word_t      frame_wdata;
  logic       frame_we;
  logic [1:0] byte_idx;
  logic       rd_slot;

  byte_t      uo_nxt;
  byte_t      uio_nxt;
  byte_t      oe_nxt;

  // no new frame in the ready cycle, valid is still up then
  assign start = bus.valid && (slot == SLOT_IDLE) && !bus.ready;

  always_comb begin
    if (start) begin
      slot_nxt = 4'd1;
    end else if ((slot == SLOT_IDLE) || (slot == SLOT_LAST)) begin
      slot_nxt = SLOT_IDLE;
    end else begin
      slot_nxt = slot + 4'd1;
    end
  end

  // slot 1 is built straight from the bus, later slots from the latch
  assign frame_addr  = start ? bus.addr  : addr_q;
  assign frame_wdata = start ? bus.wdata : wdata_q;
  assign frame_we    = start ? bus.we    : we_q;
  assign byte_idx    = slot_nxt[1:0] - 2'd1;  // slots 1..4 -> bytes 0..3

  always_comb begin
    uo_nxt  = '0;
    uio_nxt = '0;
    oe_nxt  = '0;
    case (slot_nxt)
      4'd1, 4'd2, 4'd3, 4'd4: begin
        uo_nxt  = frame_addr[byte_idx*8 +: 8];
        uio_nxt = frame_we ? frame_wdata[byte_idx*8 +: 8] : '0;
        oe_nxt  = '1;
      end
      SLOT_CMD: begin
        uo_nxt = {7'b0, frame_we};  // bit 0 is write
        oe_nxt = '1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot      <= SLOT_IDLE;
      bus.ready <= 1'b0;
      uo_out    <= '0;
      uio_out   <= '0;
      uio_oe    <= '0;
    end else begin
      slot      <= slot_nxt;
      bus.ready <= (slot == SLOT_LAST);
      uo_out    <= uo_nxt;
      uio_out   <= uio_nxt;
      uio_oe    <= oe_nxt;
    end
  end

  assign rd_slot = (slot >= SLOT_RD0) && (slot <= SLOT_LAST);

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
      we_q    <= bus.we;
    end
    if (rd_slot) begin
      rd_shift <= {uio_in, rd_shift[WORD_W-1:8]};  // end of slot sample
    end
  end

  assign bus.rdata = rd_shift;  // full word by the ready cycle

endmodule

//--- design/cpu_handler_top.sv
`timescale 1ns/1ns

module cpu_handler_top #(
  parameter bus_pkg::addr_t RESET_VECTOR = '0
) (
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  logic unused;

  cpu_bus_if bus_if (.clk(clk));

  acc_cpu #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_cpu (
    .clk  (clk),
    .rst_n(rst_n),
    .run  (ui_in[0]),  // run enable
    .bus  (bus_if.cpu)
  );

  pin_bridge u_bridge (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus    (bus_if.bridge),
    .uo_out (uo_out),
    .uio_out(uio_out),
    .uio_oe (uio_oe),
    .uio_in (uio_in)
  );

  // pins with no function here
  assign unused = &{ena, ui_in[7:1], 1'b0};

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ns

// free running clock for the testbench
module tb_clk_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

//--- verif/bridge_asserts.sv
`timescale 1ns/1ns

module bridge_asserts (
  input logic       clk,
  input logic       rst_n,
  input logic [7:0] uio_oe,
  input logic [7:0] uo_out,
  input logic       ready,
  input logic [3:0] slot
);

  // output enable moves as one byte
  oe_whole_byte: assert property (@(posedge clk) disable iff (!rst_n)
    (uio_oe == 8'h00) || (uio_oe == 8'hff))
    else $error("uio_oe is neither all ones nor all zero");

  ready_single: assert property (@(posedge clk) disable iff (!rst_n)
    ready |=> !ready)
    else $error("ready held high for two cycles");

  // slot 6 follows the command byte
  uo_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ((uio_oe == 8'h00) && (slot != 4'd6)) |-> (uo_out == 8'h00))
    else $error("uo_out not zero while uio_oe is low");

  oe_five_cycles: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(uio_oe[0]) |-> uio_oe[0] ##1 uio_oe[0] ##1 uio_oe[0] ##1 uio_oe[0]
      ##1 uio_oe[0] ##1 !uio_oe[0])
    else $error("uio_oe high for other than five cycles");

endmodule

bind pin_bridge bridge_asserts u_asserts (
  .clk   (clk),
  .rst_n (rst_n),
  .uio_oe(uio_oe),
  .uo_out(uo_out),
  .ready (bus.ready),
  .slot  (slot)
);

//--- verif/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int FRAMES        = 300;
  localparam int FRAME_TIMEOUT = 100;
  localparam int HALT_WINDOW   = 200;
  localparam logic [3:0] OP_LDA = 4'd1;
  localparam logic [3:0] OP_ADD = 4'd2;
  localparam logic [3:0] OP_STA = 4'd3;
  localparam logic [3:0] OP_JMP = 4'd4;
  localparam logic [3:0] OP_JZ  = 4'd5;
  localparam logic [3:0] OP_HLT = 4'd6;

  logic        clk;
  logic        rst_n;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  logic        ena;
  logic [7:0]  uo_out;
  logic [7:0]  uio_out;
  logic [7:0]  uio_oe;

  integer      seed;
  int          errors;
  int          frames;
  logic [31:0] mem [0:255];  // word addressed by addr[9:2]
  logic [31:0] m_pc;
  logic [31:0] m_acc;
  logic [31:0] m_ir;
  int          m_phase;      // 0 fetch, 1 data access, 2 halted
  logic        run_d1;
  logic        run_d2;       // run as seen by the cpu two edges back
  logic        gate_en;
  int          run_left;

  tb_clk_gen #(.PERIOD(8)) u_clk (.clk(clk));

  cpu_handler_top u_dut (
    .ui_in  (ui_in),
    .uo_out (uo_out),
    .uio_in (uio_in),
    .uio_out(uio_out),
    .uio_oe (uio_oe),
    .ena    (ena),
    .clk    (clk),
    .rst_n  (rst_n)
  );

  task automatic final_report;
    begin
      $display("errors: %0d  frames: %0d", errors, frames);
      if (errors == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    begin
      if (got !== exp) begin
        $display("Error: t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
      end
    end
  endtask

  // advance one clock and move inputs 1 ns after the edge
  task automatic step;
    begin
      @(posedge clk);
      #1;
      run_d2 = run_d1;
      run_d1 = ui_in[0];
      if (gate_en) begin
        if (run_left > 0) begin
          run_left--;
          if (run_left == 0) ui_in[0] = 1'b1;
        end else if (($unsigned($random(seed)) % 40) == 0) begin
          run_left = 1 + ($unsigned($random(seed)) % 20);
          ui_in[0] = 1'b0;
        end
      end
    end
  endtask

  task automatic fill_random;
    logic [31:0] r;
    logic [3:0]  op;
    begin
      for (int i = 0; i < 256; i++) begin
        r = $unsigned($random(seed));
        op = ((r % 64) == 0) ? OP_HLT : 4'(1 + (r % 5));
        mem[i] = {op, 28'(($unsigned($random(seed)) % 256) * 4)};
      end
      mem[0] = {OP_LDA, 28'(($unsigned($random(seed)) % 256) * 4)};  // first fetch is sane
    end
  endtask

  task automatic load_halt_program;
    begin
      for (int i = 0; i < 256; i++) mem[i] = 32'h0;  // opcode 0 does nothing
      mem[0]  = {OP_LDA, 28'h40};
      mem[1]  = {OP_ADD, 28'h44};
      mem[2]  = {OP_STA, 28'h48};
      mem[3]  = {OP_JZ, 28'h0};   // acc is nonzero here
      mem[4]  = {OP_HLT, 28'h0};
      mem[16] = 32'hffff_fff0;
      mem[17] = 32'h0000_0020;    // sum wraps to 0x10
    end
  endtask

  task automatic model_expect(output logic [31:0] addr, output logic we, output logic [31:0] data);
    begin
      data = m_acc;
      if (m_phase == 0) begin
        addr = m_pc;
        we   = 1'b0;
      end else begin
        addr = {4'h0, m_ir[27:0]};
        we   = (m_ir[31:28] == OP_STA);
      end
    end
  endtask

  task automatic model_retire(input logic [31:0] rdata);
    logic [31:0] operand;
    begin
      if (m_phase == 0) begin
        m_ir = rdata;
        operand = {4'h0, rdata[27:0]};
        case (rdata[31:28])
          OP_LDA, OP_ADD, OP_STA: m_phase = 1;
          OP_JMP: m_pc = operand;
          OP_JZ:  m_pc = (m_acc == 32'h0) ? operand : m_pc + 32'd4;
          OP_HLT: m_phase = 2;
          default: m_pc = m_pc + 32'd4;
        endcase
      end else begin
        if (m_ir[31:28] == OP_LDA) m_acc = rdata;
        if (m_ir[31:28] == OP_ADD) m_acc = m_acc + rdata;
        m_pc = m_pc + 32'd4;
        m_phase = 0;
      end
    end
  endtask

  task automatic do_reset;
    begin
      gate_en  = 1'b0;
      run_left = 0;
      rst_n    = 1'b0;
      ui_in    = 8'h00;
      uio_in   = 8'h00;
      for (int i = 0; i < 3; i++) begin
        step;
        check("uio_oe", uio_oe, 0);
        check("uo_out", uo_out, 0);
        check("uio_out", uio_out, 0);
      end
      rst_n = 1'b1;
      ui_in[0] = 1'b1;
      m_pc = 32'h0;
      m_acc = 32'h0;
      m_phase = 0;
    end
  endtask

  // watch one frame on the pins and answer it as memory
  task automatic do_frame;
    int          n;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] rword;
    logic [31:0] e_addr;
    logic [31:0] e_data;
    logic        f_we;
    logic        e_we;
    begin
      n = 0;
      while (uio_oe !== 8'hff && n < FRAME_TIMEOUT) begin
        check("uio_oe", uio_oe, 0);
        check("uo_out", uo_out, 0);
        check("uio_out", uio_out, 0);
        step;
        n++;
      end
      if (n >= FRAME_TIMEOUT) begin
        $display("timeout: no frame started within %0d cycles", FRAME_TIMEOUT);
        errors++;
        final_report;
      end else begin
        if (run_d2 !== 1'b1) begin
          $display("frame started at %0t although run was low", $time);
          errors++;
        end
        for (int s = 0; s < 4; s++) begin
          if (s > 0) step;
          check("uio_oe", uio_oe, 32'hff);
          f_addr[s*8 +: 8]  = uo_out;
          f_wdata[s*8 +: 8] = uio_out;
        end
        step;  // command slot
        check("uio_oe", uio_oe, 32'hff);
        check("uo_out[7:1]", uo_out[7:1], 0);
        check("uio_out", uio_out, 0);
        f_we = uo_out[0];
        model_expect(e_addr, e_we, e_data);
        check("addr", f_addr, e_addr);
        check("we", f_we, e_we);
        check("wdata", f_wdata, e_we ? e_data : 32'h0);
        rword = mem[f_addr[9:2]];
        if (f_we) mem[f_addr[9:2]] = f_wdata;
        for (int s = 0; s < 4; s++) begin
          step;
          check("uio_oe", uio_oe, 0);
          check("uo_out", uo_out, 0);
          check("uio_out", uio_out, 0);
          uio_in = f_we ? 8'h00 : rword[s*8 +: 8];
        end
        step;
        uio_in = 8'h00;
        model_retire(rword);
        frames++;
      end
    end
  endtask

  initial begin
    int n;
    rst_n    = 1'b0;
    ui_in    = 8'h00;
    uio_in   = 8'h00;
    ena      = 1'b1;
    seed     = 84;
    errors   = 0;
    frames   = 0;
    gate_en  = 1'b0;
    run_left = 0;
    run_d1   = 1'b0;
    run_d2   = 1'b0;

    fill_random;
    do_reset;
    gate_en = 1'b1;
    while (frames < FRAMES) begin
      do_frame;
      if (m_phase == 2) begin  // random program halted so start a fresh one
        fill_random;
        do_reset;
        gate_en = 1'b1;
      end
    end

    load_halt_program;
    do_reset;
    n = 0;
    while (m_phase != 2 && n < 20) begin
      do_frame;
      n++;
    end
    if (m_phase != 2) begin
      $display("halt program did not reach its HLT");
      errors++;
    end
    check("acc store", mem[18], 32'h0000_0010);
    n = 0;
    while (n < HALT_WINDOW && uio_oe === 8'h00) begin
      step;
      n++;
    end
    if (n < HALT_WINDOW) begin
      $display("a frame started after the processor halted");
      errors++;
    end
    final_report;
  end

endmodule

//--- build.f
design/bus_pkg.sv
design/cpu_bus_if.sv
design/acc_cpu.sv
design/pin_bridge.sv
design/cpu_handler_top.sv
verif/tb_clk_gen.sv
verif/bridge_asserts.sv
verif/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
